/* Bender.yml */
package:
  name: atop_resolver

export_include_dirs:
  - hdl

sources:
  - files:
      - hdl/obi_bus_pkg.sv
      - hdl/amo_pkg.sv
      - hdl/resp_fifo.sv
      - hdl/amo_alu.sv
      - hdl/amo_sequencer.sv
      - hdl/atop_resolver.sv
  - target: test
    files:
      - dv/tb_clk_gen.sv
      - dv/tb_atop_resolver.sv

/* dv/tb_atop_resolver.sv */
// ------------------------------
// Directed tests, memory model,
// shadow memory, LFSR and watchdog
// ------------------------------

`timescale 1ns/1ps
`default_nettype none

module tb_atop_resolver;

  localparam int unsigned NumRandom       = 120;
  localparam int unsigned WaitLimit       = 40;
  localparam int unsigned CyclesPerAccess = 12;
  localparam int unsigned NumAccess       = 16 + 9 * 2 * 3 + 4 + 5 + NumRandom;
  localparam int unsigned WatchdogCycles  = 16 + NumAccess * CyclesPerAccess;
  localparam logic [31:0] LfsrTaps        = 32'h8020_0003;

  logic                      clk;
  logic                      rst_n;
  logic                      req;
  logic                      gnt;
  obi_bus_pkg::addr_t        addr;
  logic                      we;
  obi_bus_pkg::be_t          be;
  obi_bus_pkg::data_t        wdata;
  obi_bus_pkg::id_t          aid;
  amo_pkg::atop_e            atop;
  logic                      rvalid;
  logic                      rready;
  obi_bus_pkg::data_t        rdata;
  obi_bus_pkg::id_t          rid;
  logic                      err;
  logic                      mem_req;
  logic                      mem_gnt;
  obi_bus_pkg::addr_t        mem_addr;
  logic                      mem_we;
  obi_bus_pkg::be_t          mem_be;
  obi_bus_pkg::data_t        mem_wdata;
  obi_bus_pkg::id_t          mem_aid;
  logic                      mem_rvalid = 1'b0;
  obi_bus_pkg::data_t        mem_rdata  = '0;
  logic                      mem_err    = 1'b0;
  logic [31:0]               mem_model [256];
  logic [31:0]               shadow [256];
  logic [31:0]               lfsr_q;

  tb_clk_gen #(
    .PERIOD_NS    (100),
    .RESET_CYCLES (16)
  ) u_clk_gen (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  atop_resolver dut (
    .clk_i (clk), .rst_ni (rst_n),
    .req_i (req), .gnt_o (gnt), .addr_i (addr), .we_i (we), .be_i (be),
    .wdata_i (wdata), .aid_i (aid), .atop_i (atop),
    .rvalid_o (rvalid), .rready_i (rready), .rdata_o (rdata), .rid_o (rid), .err_o (err),
    .mem_req_o (mem_req), .mem_gnt_i (mem_gnt), .mem_addr_o (mem_addr), .mem_we_o (mem_we),
    .mem_be_o (mem_be), .mem_wdata_o (mem_wdata), .mem_aid_o (mem_aid),
    .mem_rvalid_i (mem_rvalid), .mem_rdata_i (mem_rdata), .mem_err_i (mem_err)
  );

  function automatic logic [31:0] fill_word(input logic [7:0] idx);
    return {idx, ~idx, idx ^ 8'h5a, idx + 8'h33};
  endfunction

  function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] wd,
                                              input logic [3:0] b_en);
    logic [31:0] res;
    res = old;
    for (int k = 0; k < 4; k++) begin
      if (b_en[k]) res[8*k +: 8] = wd[8*k +: 8];
    end
    return res;
  endfunction

  // RISC-V AMO result from the old word a and operand b
  function automatic logic [31:0] amo_expected(input amo_pkg::atop_e op, input logic [31:0] a,
                                               input logic [31:0] b);
    case (op)
      amo_pkg::AmoSwap: return b;
      amo_pkg::AmoAdd:  return a + b;
      amo_pkg::AmoXor:  return a ^ b;
      amo_pkg::AmoOr:   return a | b;
      amo_pkg::AmoAnd:  return a & b;
      amo_pkg::AmoMin:  return ($signed(a) < $signed(b)) ? a : b;
      amo_pkg::AmoMax:  return ($signed(a) > $signed(b)) ? a : b;
      amo_pkg::AmoMinu: return (a < b) ? a : b;
      amo_pkg::AmoMaxu: return (a > b) ? a : b;
      default:          return a;
    endcase
  endfunction

  function automatic amo_pkg::atop_e op_by_index(input int unsigned idx);
    case (idx)
      0:       return amo_pkg::AmoSwap;
      1:       return amo_pkg::AmoAdd;
      2:       return amo_pkg::AmoXor;
      3:       return amo_pkg::AmoOr;
      4:       return amo_pkg::AmoAnd;
      5:       return amo_pkg::AmoMin;
      6:       return amo_pkg::AmoMax;
      7:       return amo_pkg::AmoMinu;
      default: return amo_pkg::AmoMaxu;
    endcase
  endfunction

  // Galois LFSR stepped once per bit taken
  function automatic logic [31:0] rand_bits(input int unsigned n);
    logic [31:0] v;
    v = '0;
    for (int unsigned k = 0; k < n; k++) begin
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ LfsrTaps) : (lfsr_q >> 1);
      v = {v[30:0], lfsr_q[0]};
    end
    return v;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("FAIL at %0t ns: %s is %h, expected %h", $time, name, got, exp);
      $display("Simulation failed");
      $fatal(1, "Value mismatch on %s", name);
    end
  endtask

  task automatic report_timeout(input string what);
    $display("Timeout at %0t ns: %s", $time, what);
    $display("Simulation failed");
    $fatal(1, "Handshake timeout");
  endtask

  // ------------------------------
  // Memory model with an error
  // flag on address bit 12
  // ------------------------------
  assign mem_gnt = 1'b1;

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mem_rvalid <= 1'b0;
      mem_err    <= 1'b0;
    end else begin
      mem_rvalid <= mem_req & mem_gnt;
      if (mem_req && mem_gnt) begin
        // Plain requests and write-backs carry the upstream request ID
        check_value("mem_aid_o", 32'(mem_aid), 32'(aid));
        mem_rdata <= mem_model[mem_addr[9:2]];
        mem_err   <= mem_addr[12];
        // Writes to an error address are dropped
        if (mem_we && !mem_addr[12]) begin
          mem_model[mem_addr[9:2]] <= merge_bytes(mem_model[mem_addr[9:2]], mem_wdata, mem_be);
        end
      end
    end
  end

  // Sends one request, checks the possibly held response and updates the shadow
  task automatic access_and_check(input logic wr, input amo_pkg::atop_e op,
      input obi_bus_pkg::addr_t a, input obi_bus_pkg::be_t b_en, input obi_bus_pkg::data_t wd,
      input obi_bus_pkg::id_t id, input int unsigned hold);
    obi_bus_pkg::data_t old_word;
    obi_bus_pkg::data_t held;
    int unsigned        waited;
    old_word = shadow[a[9:2]];
    @(posedge clk);
    req   <= 1'b1;
    addr  <= a;
    we    <= wr;
    be    <= b_en;
    wdata <= wd;
    aid   <= id;
    atop  <= op;
    waited = 0;
    @(negedge clk);
    while (!gnt) begin
      waited++;
      if (waited > WaitLimit) report_timeout("request was never granted");
      @(negedge clk);
    end
    @(posedge clk);
    req    <= 1'b0;
    rready <= (hold == 0);
    waited = 0;
    @(negedge clk);
    while (!rvalid) begin
      waited++;
      if (waited > WaitLimit) report_timeout("no response after the grant");
      @(negedge clk);
    end
    if (hold > 0) begin
      held = rdata;
      repeat (hold) begin
        check_value("rvalid_o", 32'(rvalid), 32'd1);
        check_value("gnt_o", 32'(gnt), 32'd0);
        check_value("rdata_o", rdata, held);
        @(negedge clk);
      end
      @(posedge clk);
      rready <= 1'b1;
      @(negedge clk);
    end
    check_value("rid_o", 32'(rid), 32'(id));
    check_value("err_o", 32'(err), 32'(a[12]));
    if (op[5] || !wr) check_value("rdata_o", rdata, old_word);
    if (!a[12]) begin
      if (op[5]) shadow[a[9:2]] = amo_expected(op, old_word, wd);
      else if (wr) shadow[a[9:2]] = merge_bytes(old_word, wd, b_en);
    end
  endtask

  // ------------------------------
  // Tests
  // ------------------------------
  task automatic plain_access_test();
    obi_bus_pkg::be_t b_en;
    for (int i = 0; i < 8; i++) begin
      b_en = (i < 2) ? 4'hf : 4'(i ^ 9);
      access_and_check(1'b1, amo_pkg::AtopNone, 32'h80 + 32'(4 * i), b_en,
                       32'hc0de_0000 + 32'(i * 32'h111), 4'(i), 0);
    end
    for (int i = 0; i < 8; i++) begin
      access_and_check(1'b0, amo_pkg::AtopNone, 32'h80 + 32'(4 * i), 4'hf, '0, 4'(i + 8), 0);
    end
  endtask

  // Operand pairs differ in sign so signed and unsigned picks disagree
  task automatic amo_results_test();
    obi_bus_pkg::addr_t a;
    obi_bus_pkg::data_t seed;
    obi_bus_pkg::data_t operand;
    for (int i = 0; i < 9; i++) begin
      for (int k = 0; k < 2; k++) begin
        a       = 32'h100 + 32'(4 * i);
        seed    = (k == 0) ? 32'h8000_0010 : 32'h0000_0005;
        operand = (k == 0) ? 32'h0000_0020 : 32'hffff_fff0;
        access_and_check(1'b1, amo_pkg::AtopNone, a, 4'hf, seed, 4'(i), 0);
        access_and_check(1'b1, op_by_index(i), a, 4'hf, operand, 4'(i + 1), 0);
        access_and_check(1'b0, amo_pkg::AtopNone, a, 4'hf, '0, 4'(i + 2), 0);
      end
    end
  endtask

  task automatic back_pressure_test();
    access_and_check(1'b1, amo_pkg::AtopNone, 32'h200, 4'hf, 32'h1234_5678, 4'h3, 5);
    access_and_check(1'b1, amo_pkg::AmoAdd, 32'h200, 4'hf, 32'h0000_0010, 4'h4, 7);
    access_and_check(1'b0, amo_pkg::AtopNone, 32'h200, 4'hf, '0, 4'h5, 3);
    access_and_check(1'b0, amo_pkg::AtopNone, 32'h200, 4'hf, '0, 4'h6, 0);
  endtask

  task automatic error_flag_test();
    access_and_check(1'b1, amo_pkg::AtopNone, 32'h240, 4'hf, 32'hdead_beef, 4'h7, 0);
    access_and_check(1'b0, amo_pkg::AtopNone, 32'h1240, 4'hf, '0, 4'h8, 0);
    access_and_check(1'b1, amo_pkg::AtopNone, 32'h1240, 4'hf, 32'h0bad_f00d, 4'h9, 0);
    access_and_check(1'b1, amo_pkg::AmoSwap, 32'h1240, 4'hf, 32'h5555_aaaa, 4'ha, 0);
    access_and_check(1'b0, amo_pkg::AtopNone, 32'h240, 4'hf, '0, 4'hb, 0);
  endtask

  task automatic random_mix_test();
    logic [1:0]         kind;
    obi_bus_pkg::addr_t a;
    obi_bus_pkg::be_t   b_en;
    obi_bus_pkg::data_t wd;
    obi_bus_pkg::id_t   id;
    amo_pkg::atop_e     op;
    int unsigned        hold;
    for (int n = 0; n < NumRandom; n++) begin
      kind = 2'(rand_bits(2));
      a    = 32'h300 + (rand_bits(2) << 2);
      b_en = 4'(rand_bits(4));
      wd   = rand_bits(32);
      id   = 4'(rand_bits(4));
      hold = (rand_bits(3) == 0) ? rand_bits(2) + 1 : 0;
      op   = kind[1] ? op_by_index(rand_bits(4) % 9) : amo_pkg::AtopNone;
      access_and_check(kind != 2'd0, op, a, b_en, wd, id, hold);
    end
  endtask

  initial begin
    repeat (WatchdogCycles) @(posedge clk);
    $display("Watchdog expired after %0d cycles", WatchdogCycles);
    $display("Simulation failed");
    $fatal(1, "Run did not finish in time");
  end

  initial begin
    req    = 1'b0;
    addr   = '0;
    we     = 1'b0;
    be     = '0;
    wdata  = '0;
    aid    = '0;
    atop   = amo_pkg::AtopNone;
    rready = 1'b1;
    lfsr_q = 32'hc774;
    for (int i = 0; i < 256; i++) begin
      mem_model[i] = fill_word(8'(i));
      shadow[i]    = fill_word(8'(i));
    end
    @(posedge rst_n);
    plain_access_test();
    amo_results_test();
    back_pressure_test();
    error_flag_test();
    random_mix_test();
    $display("Simulation completed successfully");
    $finish;
  end

endmodule

`default_nettype wire

/* dv/tb_clk_gen.sv */
// ------------------------------
// Testbench clock and reset
// ------------------------------

`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
  parameter int unsigned PERIOD_NS    = 100,
  parameter int unsigned RESET_CYCLES = 16
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // Reset released on a rising edge after the hold time
  initial begin
    rst_no = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    rst_no <= 1'b1;
  end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+hdl
hdl/obi_bus_pkg.sv
hdl/amo_pkg.sv
hdl/resp_fifo.sv
hdl/amo_alu.sv
hdl/amo_sequencer.sv
hdl/atop_resolver.sv
dv/tb_clk_gen.sv
dv/tb_atop_resolver.sv

/* hdl/amo_alu.sv */
// ------------------------------
// Operand capture and the nine
// operation atomic ALU
// ------------------------------

`timescale 1ns/1ps
`default_nettype none

module amo_alu (
  input  wire logic              clk_i,
  input  wire logic              rst_ni,
  input  wire logic              load_i,
  input  wire amo_pkg::atop_e    op_i,
  input  wire obi_bus_pkg::data_t operand_b_i,
  input  wire logic              rvalid_i,
  input  wire obi_bus_pkg::data_t rdata_i,
  output obi_bus_pkg::data_t     result_o
);

  localparam int unsigned DataWidth = $bits(obi_bus_pkg::data_t);

  amo_pkg::atop_e      op_q;
  obi_bus_pkg::data_t  operand_b_q;
  obi_bus_pkg::data_t  rdata_q;
  obi_bus_pkg::data_t  operand_a;
  logic                is_signed;
  logic [DataWidth:0]  cmp_a;
  logic [DataWidth:0]  cmp_b;
  logic [DataWidth:0]  diff;
  logic                a_less;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      op_q <= amo_pkg::AtopNone;
    end else if (load_i) begin
      op_q <= op_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (load_i) begin
      operand_b_q <= operand_b_i;
    end
    if (rvalid_i) begin
      rdata_q <= rdata_i;
    end
  end

  // Old memory word, live while the read answers
  assign operand_a = rvalid_i ? rdata_i : rdata_q;

  // ------------------------------
  // Compare via a single a - b
  // ------------------------------
  assign is_signed = (op_q == amo_pkg::AmoMin) || (op_q == amo_pkg::AmoMax);
  assign cmp_a     = {is_signed & operand_a[DataWidth-1], operand_a};
  assign cmp_b     = {is_signed & operand_b_q[DataWidth-1], operand_b_q};
  assign diff      = cmp_a + ~cmp_b + (DataWidth+1)'(1);
  assign a_less    = diff[DataWidth];

  always_comb begin
    unique case (op_q)
      amo_pkg::AmoAdd:                   result_o = operand_a + operand_b_q;
      amo_pkg::AmoAnd:                   result_o = operand_a & operand_b_q;
      amo_pkg::AmoOr:                    result_o = operand_a | operand_b_q;
      amo_pkg::AmoXor:                   result_o = operand_a ^ operand_b_q;
      amo_pkg::AmoMin, amo_pkg::AmoMinu: result_o = a_less ? operand_a : operand_b_q;
      amo_pkg::AmoMax, amo_pkg::AmoMaxu: result_o = a_less ? operand_b_q : operand_a;
      // Swap writes operand b unchanged
      default:                           result_o = operand_b_q;
    endcase
  end

endmodule

`default_nettype wire

/* hdl/amo_pkg.sv */
// ------------------------------
// Atomic opcode encoding and the
// sequencer state type
// ------------------------------

`default_nettype none

package amo_pkg;

  // OBI atop encoding, bit 5 set marks an atomic,
  // bits 4:0 carry the RISC-V funct5
  typedef enum logic [5:0] {
    AtopNone = 6'h00,
    AmoAdd   = 6'h20,
    AmoSwap  = 6'h21,
    AtopLr   = 6'h22,
    AtopSc   = 6'h23,
    AmoXor   = 6'h24,
    AmoOr    = 6'h28,
    AmoAnd   = 6'h2C,
    AmoMin   = 6'h30,
    AmoMax   = 6'h34,
    AmoMinu  = 6'h38,
    AmoMaxu  = 6'h3C
  } atop_e;

  // Request sequencer states
  typedef enum logic [1:0] {
    Idle,
    DoAmo,
    WriteBack
  } amo_state_e;

endpackage

`default_nettype wire

/* hdl/amo_sequencer.sv */
// ------------------------------
// Request FSM, memory request mux
// and response pairing
// ------------------------------

`timescale 1ns/1ps
`default_nettype none

module amo_sequencer (
  input  wire logic               clk_i,
  input  wire logic               rst_ni,
  input  wire logic               req_i,
  input  wire obi_bus_pkg::addr_t addr_i,
  input  wire logic               we_i,
  input  wire obi_bus_pkg::be_t   be_i,
  input  wire obi_bus_pkg::data_t wdata_i,
  input  wire obi_bus_pkg::id_t   aid_i,
  input  wire amo_pkg::atop_e     atop_i,
  input  wire logic               rready_i,
  input  wire logic               mem_gnt_i,
  input  wire logic               mem_rvalid_i,
  input  wire obi_bus_pkg::data_t alu_result_i,
  input  wire logic               id_empty_i,
  input  wire logic               data_empty_i,
  output logic                    gnt_o,
  output logic                    rvalid_o,
  output logic                    mem_req_o,
  output obi_bus_pkg::addr_t      mem_addr_o,
  output logic                    mem_we_o,
  output obi_bus_pkg::be_t        mem_be_o,
  output obi_bus_pkg::data_t      mem_wdata_o,
  output obi_bus_pkg::id_t        mem_aid_o,
  output logic                    alu_load_o,
  output logic                    id_push_o,
  output logic                    data_push_o,
  output logic                    pop_o
);

  amo_pkg::amo_state_e state_q, state_d;
  obi_bus_pkg::addr_t  addr_q;
  obi_bus_pkg::id_t    aid_q;
  logic                last_wb_q;
  logic                is_amo;
  logic                handshake;

  assign is_amo = atop_i inside {amo_pkg::AmoSwap, amo_pkg::AmoAdd, amo_pkg::AmoXor,
                                 amo_pkg::AmoAnd, amo_pkg::AmoOr, amo_pkg::AmoMin,
                                 amo_pkg::AmoMax, amo_pkg::AmoMinu, amo_pkg::AmoMaxu};

  assign gnt_o      = (state_q == amo_pkg::Idle) & mem_gnt_i & data_empty_i;
  assign handshake  = req_i & gnt_o;
  assign alu_load_o = handshake & is_amo;

  // ------------------------------
  // Memory request and next state
  // ------------------------------
  always_comb begin
    state_d     = state_q;
    mem_req_o   = req_i & data_empty_i;
    mem_addr_o  = addr_i;
    mem_we_o    = we_i & ~is_amo;
    mem_be_o    = be_i;
    mem_wdata_o = wdata_i;
    mem_aid_o   = aid_i;
    unique case (state_q)
      amo_pkg::Idle: begin
        if (alu_load_o) begin
          state_d = amo_pkg::DoAmo;
        end
      end
      // Memory is claimed for the full-word write-back
      amo_pkg::DoAmo, amo_pkg::WriteBack: begin
        mem_req_o   = 1'b1;
        mem_addr_o  = addr_q;
        mem_we_o    = 1'b1;
        mem_be_o    = '1;
        mem_wdata_o = alu_result_i;
        mem_aid_o   = aid_q;
        if (mem_gnt_i) begin
          state_d = amo_pkg::Idle;
        end else begin
          state_d = amo_pkg::WriteBack;
        end
      end
      default: state_d = amo_pkg::Idle;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= amo_pkg::Idle;
      last_wb_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (mem_req_o && mem_gnt_i) begin
        last_wb_q <= (state_q != amo_pkg::Idle);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (alu_load_o) begin
      addr_q <= addr_i;
      aid_q  <= aid_i;
    end
  end

  // Response pairing, the write-back answer is dropped
  assign id_push_o   = handshake;
  assign data_push_o = mem_rvalid_i & ~last_wb_q;
  assign rvalid_o    = ~id_empty_i & ~data_empty_i;
  assign pop_o       = rvalid_o & rready_i;

  a_no_lrsc : assert property (@(posedge clk_i) disable iff (!rst_ni)
    handshake |-> !(atop_i inside {amo_pkg::AtopLr, amo_pkg::AtopSc}));
  a_mem_latency : assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_rvalid_i == $past(mem_req_o && mem_gnt_i));

endmodule

`default_nettype wire

/* hdl/atop_config.svh */
// ------------------------------
// Width and depth macros for the
// atomic memory operation resolver
// ------------------------------

`ifndef ATOP_CONFIG_SVH
`define ATOP_CONFIG_SVH

// Upstream and memory address width
`define ATOP_ADDR_WIDTH 32

// Data word width, the ALU only supports 32
`define ATOP_DATA_WIDTH 32

// Request ID width
`define ATOP_ID_WIDTH 4

// Entries in each response FIFO
`define ATOP_RESP_DEPTH 2

`endif

/* hdl/atop_resolver.sv */
// ------------------------------
// Atomic memory operation resolver
// top level: sequencer, ALU and
// the two response FIFOs
// ------------------------------

`timescale 1ns/1ps
`default_nettype none

`include "atop_config.svh"

module atop_resolver (
  input  wire logic               clk_i,
  input  wire logic               rst_ni,
  // Upstream OBI port
  input  wire logic               req_i,
  output logic                    gnt_o,
  input  wire obi_bus_pkg::addr_t addr_i,
  input  wire logic               we_i,
  input  wire obi_bus_pkg::be_t   be_i,
  input  wire obi_bus_pkg::data_t wdata_i,
  input  wire obi_bus_pkg::id_t   aid_i,
  input  wire amo_pkg::atop_e     atop_i,
  output logic                    rvalid_o,
  input  wire logic               rready_i,
  output obi_bus_pkg::data_t      rdata_o,
  output obi_bus_pkg::id_t        rid_o,
  output logic                    err_o,
  // Memory port
  output logic                    mem_req_o,
  input  wire logic               mem_gnt_i,
  output obi_bus_pkg::addr_t      mem_addr_o,
  output logic                    mem_we_o,
  output obi_bus_pkg::be_t        mem_be_o,
  output obi_bus_pkg::data_t      mem_wdata_o,
  output obi_bus_pkg::id_t        mem_aid_o,
  input  wire logic               mem_rvalid_i,
  input  wire obi_bus_pkg::data_t mem_rdata_i,
  input  wire logic               mem_err_i
);

  logic                      alu_load;
  obi_bus_pkg::data_t        alu_result;
  logic                      id_push;
  logic                      data_push;
  logic                      pop;
  logic                      id_empty;
  logic                      data_empty;
  obi_bus_pkg::rsp_payload_t rsp_in;
  obi_bus_pkg::rsp_payload_t rsp_out;

  assign rsp_in  = '{data: mem_rdata_i, err: mem_err_i};
  assign rdata_o = rsp_out.data;
  assign err_o   = rsp_out.err;

  amo_sequencer u_sequencer (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .req_i        (req_i),
    .addr_i       (addr_i),
    .we_i         (we_i),
    .be_i         (be_i),
    .wdata_i      (wdata_i),
    .aid_i        (aid_i),
    .atop_i       (atop_i),
    .rready_i     (rready_i),
    .mem_gnt_i    (mem_gnt_i),
    .mem_rvalid_i (mem_rvalid_i),
    .alu_result_i (alu_result),
    .id_empty_i   (id_empty),
    .data_empty_i (data_empty),
    .gnt_o        (gnt_o),
    .rvalid_o     (rvalid_o),
    .mem_req_o    (mem_req_o),
    .mem_addr_o   (mem_addr_o),
    .mem_we_o     (mem_we_o),
    .mem_be_o     (mem_be_o),
    .mem_wdata_o  (mem_wdata_o),
    .mem_aid_o    (mem_aid_o),
    .alu_load_o   (alu_load),
    .id_push_o    (id_push),
    .data_push_o  (data_push),
    .pop_o        (pop)
  );

  amo_alu u_alu (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .load_i      (alu_load),
    .op_i        (atop_i),
    .operand_b_i (wdata_i),
    .rvalid_i    (mem_rvalid_i),
    .rdata_i     (mem_rdata_i),
    .result_o    (alu_result)
  );

  // ------------------------------
  // Response buffers
  // ------------------------------
  resp_fifo #(
    .payload_t (obi_bus_pkg::id_t),
    .DEPTH     (`ATOP_RESP_DEPTH)
  ) u_id_fifo (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (id_push),
    .pop_i   (pop),
    .data_i  (aid_i),
    .data_o  (rid_o),
    .empty_o (id_empty),
    .full_o  ()
  );

  resp_fifo #(
    .payload_t (obi_bus_pkg::rsp_payload_t),
    .DEPTH     (`ATOP_RESP_DEPTH)
  ) u_data_fifo (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (data_push),
    .pop_i   (pop),
    .data_i  (rsp_in),
    .data_o  (rsp_out),
    .empty_o (data_empty),
    .full_o  ()
  );

endmodule

`default_nettype wire

/* hdl/obi_bus_pkg.sv */
// ------------------------------
// OBI bus field types and the
// buffered response payload
// ------------------------------

`default_nettype none

`include "atop_config.svh"

package obi_bus_pkg;

  // Address phase fields
  typedef logic [`ATOP_ADDR_WIDTH-1:0]   addr_t;
  typedef logic [`ATOP_DATA_WIDTH-1:0]   data_t;
  typedef logic [`ATOP_DATA_WIDTH/8-1:0] be_t;
  typedef logic [`ATOP_ID_WIDTH-1:0]     id_t;

  // Response data held until upstream takes it
  typedef struct packed {
    data_t data;
    logic  err;
  } rsp_payload_t;

endpackage

`default_nettype wire

/* hdl/resp_fifo.sv */
// ------------------------------
// Fall-through FIFO with a type
// parameter for its payload
// ------------------------------

`timescale 1ns/1ps
`default_nettype none

module resp_fifo #(
  parameter type         payload_t = logic,
  parameter int unsigned DEPTH     = 2
) (
  input  wire logic     clk_i,
  input  wire logic     rst_ni,
  input  wire logic     push_i,
  input  wire logic     pop_i,
  input  wire payload_t data_i,
  output payload_t      data_o,
  output logic          empty_o,
  output logic          full_o
);

  localparam int unsigned PtrWidth = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  payload_t              mem_q [DEPTH];
  logic [PtrWidth-1:0]   rd_ptr_q;
  logic [PtrWidth-1:0]   wr_ptr_q;
  logic [PtrWidth:0]     cnt_q;
  logic                  store_empty;
  logic                  do_push;
  logic                  do_pop;

  assign store_empty = (cnt_q == '0);

  // A push into an empty FIFO that is popped at once never gets stored
  assign do_push = push_i & ~(store_empty & pop_i);
  assign do_pop  = pop_i & ~store_empty;

  // Fall through when nothing is stored
  assign data_o  = store_empty ? data_i : mem_q[rd_ptr_q];
  assign empty_o = store_empty & ~push_i;
  assign full_o  = (cnt_q == (PtrWidth+1)'(DEPTH));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == PtrWidth'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrWidth'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      cnt_q <= cnt_q + (PtrWidth+1)'(do_push) - (PtrWidth+1)'(do_pop);
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  a_no_push_full : assert property (@(posedge clk_i) disable iff (!rst_ni)
    push_i |-> !full_o);
  a_no_pop_empty : assert property (@(posedge clk_i) disable iff (!rst_ni)
    pop_i |-> !empty_o);

endmodule

`default_nettype wire
